// File: common/mul_pkg.sv
package mul_pkg;

	localparam int OP_W       = 16;
	localparam int HALF_W     = 8;
	localparam int RES_W      = 32;
	localparam int STEPS_FULL = 4;
	localparam int STEPS_LANE = 2;

	// Step code doubles as the shifter mode
	typedef logic [1:0] step_t;

	localparam step_t STEP_LL = 2'b00;	// Weight 0
	localparam step_t STEP_HL = 2'b01;	// Weight 8
	localparam step_t STEP_LH = 2'b10;	// Weight 8
	localparam step_t STEP_HH = 2'b11;	// Weight 16

	typedef struct packed {
		logic [OP_W-1:0] a;
		logic [OP_W-1:0] b;
		logic            is_signed;
		logic            lane_mode;
	} mul_req_t;

	// One 8x8 job for the sub-multiplier
	typedef struct packed {
		logic [HALF_W-1:0] x;
		logic [HALF_W-1:0] y;
		logic              x_s;
		logic              y_s;
		step_t             step;
		logic              lane;
	} sub_op_t;

	typedef struct packed {
		logic [2*HALF_W-1:0] prod;
		logic                prod_s;	// Read prod as signed
		step_t               step;
		logic                lane;
		logic                vld;
	} pp_t;

	typedef struct packed {
		logic [OP_W-1:0] hi;
		logic [OP_W-1:0] lo;
	} lanes_t;

	// Same word, either one 32-bit product or two lane products
	typedef union packed {
		logic [RES_W-1:0] full;
		lanes_t           lanes;
	} mul_res_u;

endpackage

// File: src/mul_ctrl.sv
module mul_ctrl (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              start,
	input  mul_pkg::mul_req_t req,
	output logic              busy,
	output logic              done,
	output logic              clr,
	output mul_pkg::sub_op_t  op,
	output logic              op_vld
);

	mul_pkg::mul_req_t req_q;
	mul_pkg::sub_op_t  op_next;
	mul_pkg::step_t    step;

	logic       accept;
	logic       issuing;
	logic [1:0] cnt;
	logic       last_step;
	logic       last_q;
	logic       last_d1;

	assign accept = start & ~busy;	// Start while busy is dropped

	assign last_step = req_q.lane_mode ?
		(cnt == 2'(mul_pkg::STEPS_LANE - 1)) :
		(cnt == 2'(mul_pkg::STEPS_FULL - 1));

	// Lane mode only runs LL then HH
	always_comb begin
		if (req_q.lane_mode) begin
			step = (cnt == 2'd0) ? mul_pkg::STEP_LL : mul_pkg::STEP_HH;
		end else begin
			step = mul_pkg::step_t'(cnt);
		end
	end

	always_comb begin
		op_next.step = step;
		op_next.lane = req_q.lane_mode;
		op_next.x = step[0] ? req_q.a[mul_pkg::OP_W-1:mul_pkg::HALF_W] :
			req_q.a[mul_pkg::HALF_W-1:0];
		op_next.y = step[1] ? req_q.b[mul_pkg::OP_W-1:mul_pkg::HALF_W] :
			req_q.b[mul_pkg::HALF_W-1:0];
		if (req_q.lane_mode) begin
			op_next.x_s = req_q.is_signed;
			op_next.y_s = req_q.is_signed;
		end else begin
			// Only the high bytes carry the sign of a full operand
			op_next.x_s = req_q.is_signed & step[0];
			op_next.y_s = req_q.is_signed & step[1];
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy    <= 1'b0;
			issuing <= 1'b0;
			cnt     <= '0;
			clr     <= 1'b0;
			op_vld  <= 1'b0;
			last_q  <= 1'b0;
			last_d1 <= 1'b0;
			done    <= 1'b0;
		end else begin
			clr     <= accept;
			op_vld  <= issuing;
			last_q  <= issuing & last_step;
			last_d1 <= last_q;	// Covers sub_mul and accumulator latency
			done    <= last_d1;
			if (accept) begin
				busy    <= 1'b1;
				issuing <= 1'b1;
				cnt     <= '0;
			end else begin
				if (issuing) begin
					cnt <= cnt + 2'd1;
					if (last_step) begin
						issuing <= 1'b0;
					end
				end
				if (last_d1) begin
					busy <= 1'b0;	// Falls on the done edge
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			req_q <= req;
		end
		if (issuing) begin
			op <= op_next;
		end
	end

endmodule

// File: src/sub_mul.sv
module sub_mul (
	input  logic             clk,
	input  logic             arst_n,
	input  mul_pkg::sub_op_t op,
	input  logic             op_vld,
	output mul_pkg::pp_t     pp
);

	logic signed [mul_pkg::HALF_W:0]     xe;
	logic signed [mul_pkg::HALF_W:0]     ye;
	logic signed [2*mul_pkg::HALF_W+1:0] prod_full;

	logic                        vld_q;
	logic [2*mul_pkg::HALF_W-1:0] prod_q;
	logic                        prod_s_q;
	mul_pkg::step_t              step_q;
	logic                        lane_q;

	// Each operand extended by its own sign flag
	assign xe = {op.x_s & op.x[mul_pkg::HALF_W-1], op.x};
	assign ye = {op.y_s & op.y[mul_pkg::HALF_W-1], op.y};
	assign prod_full = xe * ye;	// Fits in 16 bits for every sign mix

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			vld_q <= 1'b0;
		end else begin
			vld_q <= op_vld;
		end
	end

	always_ff @(posedge clk) begin
		if (op_vld) begin
			prod_q   <= prod_full[2*mul_pkg::HALF_W-1:0];
			prod_s_q <= op.x_s | op.y_s;
			step_q   <= op.step;
			lane_q   <= op.lane;
		end
	end

	assign pp.prod   = prod_q;
	assign pp.prod_s = prod_s_q;
	assign pp.step   = step_q;
	assign pp.lane   = lane_q;
	assign pp.vld    = vld_q;

endmodule

// File: shifter/pp_shifter.sv
module pp_shifter (
	input  mul_pkg::pp_t             pp,
	output logic [mul_pkg::RES_W-1:0] placed
);

	logic ext;

	assign ext = pp.prod_s & pp.prod[2*mul_pkg::HALF_W-1];	// Sign fill

	always_comb begin
		placed = '0;
		if (pp.lane) begin
			// Each lane kept in its own half
			case (pp.step)
				mul_pkg::STEP_LL: begin
					placed = {{(mul_pkg::RES_W-2*mul_pkg::HALF_W){1'b0}}, pp.prod};
				end
				mul_pkg::STEP_HH: begin
					placed = {pp.prod, {(mul_pkg::RES_W-2*mul_pkg::HALF_W){1'b0}}};
				end
				default: begin
					placed = '0;	// Not issued in lane mode
				end
			endcase
		end else begin
			case (pp.step)
				mul_pkg::STEP_LL: begin
					placed = {{(mul_pkg::RES_W-2*mul_pkg::HALF_W){ext}}, pp.prod};
				end
				mul_pkg::STEP_HL, mul_pkg::STEP_LH: begin
					placed = {{(mul_pkg::RES_W-3*mul_pkg::HALF_W){ext}}, pp.prod,
						{mul_pkg::HALF_W{1'b0}}};
				end
				default: begin
					// HH fills the top half with no room for extension
					placed = {pp.prod, {(mul_pkg::RES_W-2*mul_pkg::HALF_W){1'b0}}};
				end
			endcase
		end
	end

endmodule

// File: src/pp_accum.sv
module pp_accum (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      clr,
	input  logic                      pp_vld,
	input  logic [mul_pkg::RES_W-1:0] placed,
	output mul_pkg::mul_res_u         res
);

	logic [mul_pkg::RES_W-1:0] sum_next;

	// Wraps modulo 2^32, lane halves never overlap
	assign sum_next = res.full + placed;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			res.full <= '0;
		end else if (clr) begin
			res.full <= '0;	// New operation accepted
		end else if (pp_vld) begin
			res.full <= sum_next;
		end
	end

endmodule

// File: src/mul16_iter.sv
module mul16_iter (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              start,
	input  mul_pkg::mul_req_t req,
	output logic              busy,
	output logic              done,
	output mul_pkg::mul_res_u res
);

	logic                      clr;
	logic                      op_vld;
	mul_pkg::sub_op_t          op;
	mul_pkg::pp_t              pp;
	logic [mul_pkg::RES_W-1:0] placed;

	mul_ctrl u_ctrl (
		.clk    (clk),
		.arst_n (arst_n),
		.start  (start),
		.req    (req),
		.busy   (busy),
		.done   (done),
		.clr    (clr),
		.op     (op),
		.op_vld (op_vld)
	);

	sub_mul u_sub_mul (
		.clk    (clk),
		.arst_n (arst_n),
		.op     (op),
		.op_vld (op_vld),
		.pp     (pp)
	);

	pp_shifter u_shifter (
		.pp     (pp),
		.placed (placed)
	);

	pp_accum u_accum (
		.clk    (clk),
		.arst_n (arst_n),
		.clr    (clr),
		.pp_vld (pp.vld),
		.placed (placed),
		.res    (res)
	);

endmodule

// File: verification/tb_clk_gen.sv
module tb_clk_gen #(
	parameter int RST_CYCLES = 16
) (
	output logic clk,
	output logic arst_n
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;	// 4 ns period
	end

	initial begin
		arst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		arst_n <= 1'b1;
	end

endmodule

// File: verification/mul16_iter_props.sv
module mul16_iter_props (
	input logic clk,
	input logic arst_n,
	input logic busy,
	input logic done
);
	timeunit 1ns;
	timeprecision 1ps;

	// Single cycle pulse
	done_one_cycle: assert property (
		@(posedge clk) disable iff (!arst_n)
		done |=> !done
	) else $error("done held for more than one cycle");

	done_after_busy: assert property (
		@(posedge clk) disable iff (!arst_n)
		done |-> $past(busy)
	) else $error("done without busy in the cycle before");

	// busy falls on the done edge
	idle_on_done: assert property (
		@(posedge clk) disable iff (!arst_n)
		done |-> !busy
	) else $error("busy still high while done is high");

endmodule

bind mul16_iter mul16_iter_props u_props (
	.clk    (clk),
	.arst_n (arst_n),
	.busy   (busy),
	.done   (done)
);

// File: verification/tb_mul16_iter.sv
module tb_mul16_iter;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int          RST_CYCLES = 16;
	localparam logic [31:0] SEED       = 32'hb54c3cb4;
	localparam int          N_RAND     = 200;
	localparam int          N_CORNER   = 9;
	localparam int          FULL_LAT   = 6;
	localparam int          LANE_LAT   = 4;
	localparam int          OP_LIMIT   = 16;
	localparam int          HOLD_IDLE  = 12;
	localparam int          TOTAL_OPS  = 1 + 2 * (N_RAND + N_CORNER) + N_RAND + 2 + 2;
	localparam int          TIMEOUT_CYCLES = TOTAL_OPS * 8 + RST_CYCLES;

	logic              clk;
	logic              arst_n;
	logic              start;
	mul_pkg::mul_req_t req;
	logic              busy;
	logic              done;
	mul_pkg::mul_res_u res;

	logic [31:0] rng_state;
	int          errors;
	int          op_count;
	int          cycle_cnt;

	logic [15:0] corner_u [3] = '{16'h0000, 16'h0001, 16'hFFFF};
	logic [15:0] corner_s [3] = '{16'h8000, 16'h7FFF, 16'hFFFF};

	tb_clk_gen #(.RST_CYCLES(RST_CYCLES)) u_clk_gen (
		.clk    (clk),
		.arst_n (arst_n)
	);

	mul16_iter u_dut (
		.clk    (clk),
		.arst_n (arst_n),
		.start  (start),
		.req    (req),
		.busy   (busy),
		.done   (done),
		.res    (res)
	);

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic mul_pkg::mul_req_t make_req(input logic [15:0] a, input logic [15:0] b,
		input logic sgn, input logic lane);
		mul_pkg::mul_req_t r;
		r.a = a;
		r.b = b;
		r.is_signed = sgn;
		r.lane_mode = lane;
		return r;
	endfunction

	// Reference model straight from the operand rules
	function automatic mul_pkg::mul_res_u expected_result(input mul_pkg::mul_req_t r);
		mul_pkg::mul_res_u  e;
		logic signed [31:0] fa;
		logic signed [31:0] fb;
		logic signed [15:0] lo_a;
		logic signed [15:0] lo_b;
		logic signed [15:0] hi_a;
		logic signed [15:0] hi_b;
		fa = {{16{r.is_signed & r.a[15]}}, r.a};
		fb = {{16{r.is_signed & r.b[15]}}, r.b};
		lo_a = {{8{r.is_signed & r.a[7]}}, r.a[7:0]};
		lo_b = {{8{r.is_signed & r.b[7]}}, r.b[7:0]};
		hi_a = {{8{r.is_signed & r.a[15]}}, r.a[15:8]};
		hi_b = {{8{r.is_signed & r.b[15]}}, r.b[15:8]};
		e = '0;
		if (r.lane_mode) begin
			e.lanes.lo = lo_a * lo_b;	// Wraps to 16 bits per lane
			e.lanes.hi = hi_a * hi_b;
		end else begin
			e.full = fa * fb;
		end
		return e;
	endfunction

	task automatic random_req(input logic lane, input logic sgn, output mul_pkg::mul_req_t r);
		rng_state = lcg_step(rng_state);
		r.a = rng_state[31:16];
		rng_state = lcg_step(rng_state);
		r.b = rng_state[31:16];
		r.is_signed = sgn;
		r.lane_mode = lane;
	endtask

	task automatic report_mismatch(input string sig, input logic [31:0] exp,
		input logic [31:0] act);
		$display("FAIL t=%0t %s expected %h got %h", $time, sig, exp, act);
		errors++;
	endtask

	task automatic report_error(input string msg);
		$display("ERROR t=%0t %s", $time, msg);
		errors++;
	endtask

	task automatic finish_test(input string name, input int ops, input int first_err);
		$display("%-24s %4d ops  %0d errors", name, ops, errors - first_err);
	endtask

	// poke_cycle > 0 raises start again that many edges after the accept edge
	task automatic run_op(
		input  mul_pkg::mul_req_t r,
		input  mul_pkg::mul_req_t poke_req,
		input  int                poke_cycle,
		output mul_pkg::mul_res_u got,
		output int                lat
	);
		int cyc;
		cyc = 0;
		lat = -1;
		got = '0;
		@(posedge clk);
		start <= 1'b1;
		req   <= r;
		while (lat < 0 && cyc < OP_LIMIT) begin
			@(posedge clk);	// cyc 0 is the accept edge
			start <= (cyc + 1 == poke_cycle);
			if (cyc + 1 == poke_cycle) begin
				req <= poke_req;
			end
			@(negedge clk);
			if (done) begin
				lat = cyc;
				got = res;
				if (busy) begin
					report_error("busy still high while done is high");
				end
			end else if (!busy) begin
				report_error("busy dropped before done");
			end
			cyc++;
		end
		op_count++;
		if (lat < 0) begin
			report_error("done never arrived");
		end
	endtask

	task automatic compare_result(input mul_pkg::mul_req_t r, input mul_pkg::mul_res_u got,
		input int lat);
		mul_pkg::mul_res_u exp;
		int                exp_lat;
		exp = expected_result(r);
		exp_lat = r.lane_mode ? LANE_LAT : FULL_LAT;
		if (lat != exp_lat) begin
			report_mismatch("done latency", exp_lat, lat);
		end
		if (r.lane_mode) begin
			if (got.lanes.lo !== exp.lanes.lo) begin
				report_mismatch("res.lanes.lo", {16'h0000, exp.lanes.lo}, {16'h0000, got.lanes.lo});
			end
			if (got.lanes.hi !== exp.lanes.hi) begin
				report_mismatch("res.lanes.hi", {16'h0000, exp.lanes.hi}, {16'h0000, got.lanes.hi});
			end
		end else if (got.full !== exp.full) begin
			report_mismatch("res.full", exp.full, got.full);
		end
	endtask

	task automatic check_op(input mul_pkg::mul_req_t r);
		mul_pkg::mul_res_u got;
		int                lat;
		run_op(r, r, 0, got, lat);
		compare_result(r, got, lat);
	endtask

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("Timeout after %0d cycles, the run did not complete", TIMEOUT_CYCLES);
		$display("Regression failed");
		$finish;
	end

	initial begin
		mul_pkg::mul_req_t r;
		mul_pkg::mul_req_t r2;
		mul_pkg::mul_res_u got;
		mul_pkg::mul_res_u held;
		int                lat;
		int                mark;
		int                ops0;
		start = 1'b0;
		req = '0;
		rng_state = SEED;
		errors = 0;
		op_count = 0;

		wait (arst_n === 1'b1);
		@(negedge clk);
		mark = errors;
		if (busy !== 1'b0) begin
			report_mismatch("busy", 32'd0, {31'd0, busy});
		end
		if (done !== 1'b0) begin
			report_mismatch("done", 32'd0, {31'd0, done});
		end
		if (res.full !== 32'd0) begin
			report_mismatch("res.full", 32'd0, res.full);
		end
		finish_test("reset state", 1, mark);

		mark = errors;
		ops0 = op_count;
		foreach (corner_u[i]) begin
			foreach (corner_u[j]) begin
				check_op(make_req(corner_u[i], corner_u[j], 1'b0, 1'b0));
			end
		end
		for (int n = 0; n < N_RAND; n++) begin
			random_req(1'b0, 1'b0, r);
			check_op(r);
		end
		finish_test("full unsigned", op_count - ops0, mark);

		mark = errors;
		ops0 = op_count;
		foreach (corner_s[i]) begin
			foreach (corner_s[j]) begin
				check_op(make_req(corner_s[i], corner_s[j], 1'b1, 1'b0));
			end
		end
		for (int n = 0; n < N_RAND; n++) begin
			random_req(1'b0, 1'b1, r);
			check_op(r);
		end
		finish_test("full signed", op_count - ops0, mark);

		mark = errors;
		ops0 = op_count;
		for (int n = 0; n < N_RAND; n++) begin
			rng_state = lcg_step(rng_state);
			random_req(1'b1, rng_state[31], r);
			check_op(r);
		end
		finish_test("lane mode", op_count - ops0, mark);

		// Second start lands while busy and has to be dropped
		mark = errors;
		ops0 = op_count;
		random_req(1'b0, 1'b1, r);
		random_req(1'b1, 1'b0, r2);
		r2.a = ~r.a;
		run_op(r, r2, 2, got, lat);
		compare_result(r, got, lat);
		@(negedge clk);
		if (busy) begin
			report_error("busy restarted after a start that came while busy");
		end
		random_req(1'b1, 1'b0, r);
		random_req(1'b0, 1'b1, r2);
		r2.b = ~r.b;
		run_op(r, r2, 1, got, lat);
		compare_result(r, got, lat);
		@(negedge clk);
		if (busy) begin
			report_error("busy restarted after a start that came while busy");
		end
		finish_test("start while busy", op_count - ops0, mark);

		mark = errors;
		ops0 = op_count;
		random_req(1'b0, 1'b1, r);
		check_op(r);
		held = expected_result(r);
		repeat (HOLD_IDLE) begin
			@(negedge clk);
			if (res.full !== held.full) begin
				report_mismatch("res.full", held.full, res.full);
			end
		end
		random_req(1'b1, 1'b1, r);
		check_op(r);
		finish_test("result hold", op_count - ops0, mark);

		$display("Tests 6, operations %0d, errors %0d", op_count, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// File: mul16_iter.f
common/mul_pkg.sv
src/mul_ctrl.sv
src/sub_mul.sv
shifter/pp_shifter.sv
src/pp_accum.sv
src/mul16_iter.sv
verification/tb_clk_gen.sv
verification/mul16_iter_props.sv
verification/tb_mul16_iter.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the mul16_iter regression with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_mul16_iter \
	-f mul16_iter.f \
	-o sim_mul16_iter

./obj_dir/sim_mul16_iter 2>&1 | tee sim.log

if grep -qx "Regression passed" sim.log; then
	exit 0
else
	exit 1
fi
